//--- Bender.yml
package:
  name: windowed_mem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_pkg.sv
      - verilog/bus_pkg.sv
      - verilog/mem_access_if.sv
      - verilog/window_decoder.sv
      - verilog/word_store.sv
      - verilog/avmm_slave_ctrl.sv
      - verilog/windowed_mem_top.sv
      - target: test
        files:
          - testbench/windowed_mem_assert.sv
          - testbench/tb_windowed_mem.sv

//--- build.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/bus_pkg.sv
verilog/mem_access_if.sv
verilog/window_decoder.sv
verilog/word_store.sv
verilog/avmm_slave_ctrl.sv
verilog/windowed_mem_top.sv
testbench/windowed_mem_assert.sv
testbench/tb_windowed_mem.sv

//--- testbench/tb_windowed_mem.sv
// windowed memory testbench
module tb_windowed_mem;

  timeunit 1ns;
  timeprecision 1ps;

  // transaction kinds
  localparam logic [1:0] OP_RD   = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_BOTH = 2'd2;

  // avalon response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // cycles allowed for waitrequest to drop
  localparam int WAIT_LIMIT = 20;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [1:0]  exp_resp;
  } txn_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] address;
  logic [3:0]  byteenable;
  logic [31:0] writedata;
  logic        read;
  logic        write;
  logic [31:0] readdata;
  logic        waitrequest;
  logic [1:0]  response;

  // stimulus and expected results, applied in order
  txn_t txn_table[$];

  windowed_mem_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .address     (address),
    .byteenable  (byteenable),
    .writedata   (writedata),
    .read        (read),
    .write       (write),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .response    (response)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // a failed bound assertion ends the run at once
  always @(dut0.ctrl0.chk0.fail_count)
  begin
    if (dut0.ctrl0.chk0.fail_count != 0)
    begin
      report_failure("protocol assertion failed in the slave controller");
    end
  end

  function automatic void add_entry(logic [1:0] op, logic [31:0] addr, logic [3:0] be,
                                    logic [31:0] wdata, logic [31:0] exp_rdata,
                                    logic [1:0] exp_resp);
    txn_t t;
    t = '{op, addr, be, wdata, exp_rdata, exp_resp};
    txn_table.push_back(t);
  endfunction

  function automatic void build_table();
    // first and last word of every window, all writes before any read
    add_entry(OP_WR, 32'h0000_0000, 4'b1111, 32'ha0a0_0000, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'h0000_0050, 4'b1111, 32'ha0a0_0014, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hbfbe_0000, 4'b1111, 32'hb1b1_0000, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hbfbe_0024, 4'b1111, 32'hb1b1_0009, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hbfc1_fffc, 4'b1111, 32'hb2b2_0000, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hbfc2_0020, 4'b1111, 32'hb2b2_0009, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hb3ff_fffc, 4'b1111, 32'hc3c3_0000, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hb400_0020, 4'b1111, 32'hc3c3_0009, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hbfc0_0000, 4'b1111, 32'hd4d4_0000, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'hbfc0_0f0c, 4'b1111, 32'hd4d4_03c3, 32'h0, RESP_OKAY);
    // no aliasing, every word survives the others
    add_entry(OP_RD, 32'h0000_0000, 4'b1111, 32'h0, 32'ha0a0_0000, RESP_OKAY);
    add_entry(OP_RD, 32'h0000_0050, 4'b1111, 32'h0, 32'ha0a0_0014, RESP_OKAY);
    add_entry(OP_RD, 32'hbfbe_0000, 4'b1111, 32'h0, 32'hb1b1_0000, RESP_OKAY);
    add_entry(OP_RD, 32'hbfbe_0024, 4'b1111, 32'h0, 32'hb1b1_0009, RESP_OKAY);
    add_entry(OP_RD, 32'hbfc1_fffc, 4'b1111, 32'h0, 32'hb2b2_0000, RESP_OKAY);
    add_entry(OP_RD, 32'hbfc2_0020, 4'b1111, 32'h0, 32'hb2b2_0009, RESP_OKAY);
    add_entry(OP_RD, 32'hb3ff_fffc, 4'b1111, 32'h0, 32'hc3c3_0000, RESP_OKAY);
    add_entry(OP_RD, 32'hb400_0020, 4'b1111, 32'h0, 32'hc3c3_0009, RESP_OKAY);
    add_entry(OP_RD, 32'hbfc0_0000, 4'b1111, 32'h0, 32'hd4d4_0000, RESP_OKAY);
    add_entry(OP_RD, 32'hbfc0_0f0c, 4'b1111, 32'h0, 32'hd4d4_03c3, RESP_OKAY);
    // lanes 0 and 2 merged into 11223344
    add_entry(OP_WR, 32'h0000_0010, 4'b1111, 32'h1122_3344, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'h0000_0010, 4'b0101, 32'haabb_ccdd, 32'h0, RESP_OKAY);
    add_entry(OP_RD, 32'h0000_0010, 4'b1111, 32'h0, 32'h11bb_33dd, RESP_OKAY);
    // lane-masked reads, empty enables
    add_entry(OP_RD, 32'h0000_0010, 4'b1000, 32'h0, 32'h1100_0000, RESP_OKAY);
    add_entry(OP_RD, 32'h0000_0010, 4'b0000, 32'h0, 32'h0, RESP_OKAY);
    add_entry(OP_WR, 32'h0000_0010, 4'b0000, 32'hffff_ffff, 32'h0, RESP_OKAY);
    add_entry(OP_RD, 32'h0000_0010, 4'b1111, 32'h0, 32'h11bb_33dd, RESP_OKAY);
    // misaligned
    add_entry(OP_WR, 32'h0000_0012, 4'b1111, 32'hdead_beef, 32'h0, RESP_SLVERR);
    add_entry(OP_RD, 32'h0000_0010, 4'b1111, 32'h0, 32'h11bb_33dd, RESP_OKAY);
    add_entry(OP_RD, 32'h0000_0011, 4'b1111, 32'h0, 32'h0, RESP_SLVERR);
    // unmapped, and one word past each window end
    add_entry(OP_WR, 32'h0000_1000, 4'b1111, 32'hdead_beef, 32'h0, RESP_SLVERR);
    add_entry(OP_RD, 32'h0000_1000, 4'b1111, 32'h0, 32'h0, RESP_SLVERR);
    // word 0 untouched by the unmapped write
    add_entry(OP_RD, 32'h0000_0000, 4'b1111, 32'h0, 32'ha0a0_0000, RESP_OKAY);
    add_entry(OP_WR, 32'h0000_0054, 4'b1111, 32'hdead_beef, 32'h0, RESP_SLVERR);
    add_entry(OP_RD, 32'h0000_0050, 4'b1111, 32'h0, 32'ha0a0_0014, RESP_OKAY);
    add_entry(OP_WR, 32'hbfbe_0028, 4'b1111, 32'hdead_beef, 32'h0, RESP_SLVERR);
    add_entry(OP_RD, 32'hbfbe_0024, 4'b1111, 32'h0, 32'hb1b1_0009, RESP_OKAY);
    add_entry(OP_WR, 32'hbfc2_0024, 4'b1111, 32'hdead_beef, 32'h0, RESP_SLVERR);
    add_entry(OP_RD, 32'hbfc2_0020, 4'b1111, 32'h0, 32'hb2b2_0009, RESP_OKAY);
    add_entry(OP_RD, 32'hb400_0024, 4'b1111, 32'h0, 32'h0, RESP_SLVERR);
    add_entry(OP_WR, 32'hbfc0_0f10, 4'b1111, 32'hdead_beef, 32'h0, RESP_SLVERR);
    add_entry(OP_RD, 32'hbfc0_0f0c, 4'b1111, 32'h0, 32'hd4d4_03c3, RESP_OKAY);
    // read and write strobed together
    add_entry(OP_BOTH, 32'h0000_0010, 4'b1111, 32'h0, 32'h0, RESP_SLVERR);
    add_entry(OP_RD, 32'h0000_0010, 4'b1111, 32'h0, 32'h11bb_33dd, RESP_OKAY);
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  // one Avalon transaction with latency and result checks
  task automatic run_txn(input txn_t t, input int num);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    #1;
    address    = t.addr;
    byteenable = t.be;
    writedata  = t.wdata;
    read       = (t.op == OP_RD) || (t.op == OP_BOTH);
    write      = (t.op == OP_WR) || (t.op == OP_BOTH);
    // stall shows up combinationally in the first cycle
    #1;
    assert (waitrequest === 1'b1)
    else report_failure($sformatf("mismatch at %0t: entry %0d waitrequest expected 1 got %b",
                                  $time, num, waitrequest));
    while (!done && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      #1;
      cycles++;
      done = (waitrequest === 1'b0);
    end
    if (!done)
    begin
      report_failure($sformatf("entry %0d: transaction never completed within %0d cycles",
                               num, WAIT_LIMIT));
    end
    // released two edges after the request is first seen
    assert (cycles == 2)
    else report_failure($sformatf(
      "mismatch at %0t: entry %0d waitrequest latency expected 2 got %0d",
      $time, num, cycles));
    assert (readdata === t.exp_rdata)
    else report_failure($sformatf("mismatch at %0t: entry %0d readdata expected %h got %h",
                                  $time, num, t.exp_rdata, readdata));
    assert (response === t.exp_resp)
    else report_failure($sformatf("mismatch at %0t: entry %0d response expected %b got %b",
                                  $time, num, t.exp_resp, response));
    read  = 1'b0;
    write = 1'b0;
  endtask

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    address    = '0;
    byteenable = '0;
    writedata  = '0;
    read       = 1'b0;
    write      = 1'b0;
    build_table();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    #1;
    // quiet bus after reset
    assert (waitrequest === 1'b0)
    else report_failure($sformatf("mismatch at %0t: waitrequest expected 0 got %b",
                                  $time, waitrequest));
    assert (readdata === 32'h0 && response === RESP_OKAY)
    else report_failure($sformatf("mismatch at %0t: readdata/response expected 0/00 got %h/%b",
                                  $time, readdata, response));
    foreach (txn_table[i])
    begin
      run_txn(txn_table[i], i);
    end
    // last release still under check by the bound assertions
    repeat (2) @(posedge clk);
    #1;
    $display("Test passed");
    $finish;
  end

endmodule

//--- testbench/windowed_mem_assert.sv
// handshake assertions
module windowed_mem_assert
  import bus_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        read,
  input logic        write,
  input logic        address_ok,
  input logic        waitrequest,
  input avmm_state_t state,
  input logic        acc_en
);

  timeunit 1ns;
  timeprecision 1ps;

  logic req;

  // number of failed assertions so far
  int   fail_count;

  assign req = read | write;

  // accepted in IDLE, stalls through ACCESS, released in DONE
  property accept_latency;
    @(posedge clk) disable iff (!rst_n)
      (state == IDLE && req) |-> waitrequest ##1 waitrequest ##1 !waitrequest;
  endproperty

  // idle bus never stalls
  property idle_no_stall;
    @(posedge clk) disable iff (!rst_n)
      !req |-> !waitrequest;
  endproperty

  // error access must leave the store alone
  // bad address or both strobes at accept
  property no_store_on_error;
    @(posedge clk) disable iff (!rst_n)
      (state == IDLE && req && ((read && write) || !address_ok)) |=> !acc_en;
  endproperty

  latency_chk: assert property (accept_latency)
    else
    begin
      $error("waitrequest not released two cycles after accept");
      fail_count++;
    end

  idle_chk: assert property (idle_no_stall)
    else
    begin
      $error("waitrequest high with no request pending");
      fail_count++;
    end

  err_chk: assert property (no_store_on_error)
    else
    begin
      $error("store access enabled on an error transaction");
      fail_count++;
    end

endmodule

bind avmm_slave_ctrl windowed_mem_assert chk0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .read        (read),
  .write       (write),
  .address_ok  (address_ok),
  .waitrequest (waitrequest),
  .state       (state),
  .acc_en      (acc.en)
);

//--- verilog/avmm_slave_ctrl.sv
// avalon slave controller
module avmm_slave_ctrl
  import mem_pkg::*;
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       read,
  input  logic       write,
  input  logic       address_ok,
  input  word_idx_t  index,
  input  byte_en_t   byteenable,
  input  word_t      writedata,
  output word_t      readdata,
  output logic       waitrequest,
  output resp_t      response,
  mem_access_if.ctrl acc
);

  avmm_state_t state;

  // latched at accept
  logic  err_q;
  logic  rd_q;

  logic  req;
  logic  req_err;

  // result of the last completed transaction
  word_t data_q;
  resp_t resp_q;

  // result formed during DONE
  word_t done_data;
  resp_t done_resp;

  assign req = read | write;

  // both strobes or a bad address
  assign req_err = (read & write) | ~address_ok;

  // IDLE -> ACCESS -> DONE -> IDLE
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      err_q <= 1'b0;
      rd_q  <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (req)
          begin
            state <= ACCESS;
            err_q <= req_err;
            rd_q  <= read & ~write;
          end
        end
        ACCESS:  state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  // master holds address and data steady, so drive the store from them
  // at most one store access, and none on error
  assign acc.en         = (state == ACCESS) & ~err_q;
  assign acc.we         = ~rd_q;
  assign acc.index      = index;
  assign acc.byteenable = byteenable;
  assign acc.wdata      = writedata;

  // store rdata is valid in DONE
  assign done_data = (rd_q & ~err_q) ? acc.rdata : '0;
  assign done_resp = err_q ? SLAVEERROR : OKAY;

  // hold the result until the next DONE
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_q <= '0;
      resp_q <= OKAY;
    end
    else if (state == DONE)
    begin
      data_q <= done_data;
      resp_q <= done_resp;
    end
  end

  // stall from the first request cycle until DONE
  always_comb
  begin
    case (state)
      IDLE:    waitrequest = req;
      ACCESS:  waitrequest = 1'b1;
      default: waitrequest = 1'b0;
    endcase
  end

  assign readdata = (state == DONE) ? done_data : data_q;
  assign response = (state == DONE) ? done_resp : resp_q;

endmodule

//--- verilog/bus_pkg.sv
// avalon bus side types
package bus_pkg;

  // slave handshake states
  typedef enum logic [1:0]
  {
    // waiting for read or write
    IDLE,
    // store access in flight
    ACCESS,
    // waitrequest low, result valid
    DONE
  } avmm_state_t;

  // avalon response code
  typedef logic [1:0] resp_t;

  // normal completion
  localparam resp_t OKAY = 2'b00;

  // bad address or conflicting strobes
  localparam resp_t SLAVEERROR = 2'b10;

endpackage

//--- verilog/mem_access_if.sv
// word store access interface
interface mem_access_if
  import mem_pkg::*;
();

  // one access per transaction
  logic      en;
  // high for write, low for read
  logic      we;
  word_idx_t index;
  byte_en_t  byteenable;
  word_t     wdata;
  // lane-masked read result, registered
  word_t     rdata;

  // controller side
  modport ctrl (
    output en,
    output we,
    output index,
    output byteenable,
    output wdata,
    input  rdata
  );

  // store side
  modport store (
    input  en,
    input  we,
    input  index,
    input  byteenable,
    input  wdata,
    output rdata
  );

endinterface

//--- verilog/mem_consts.svh
// memory window constants
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// total words in the compact store
`define MEM_DEPTH 1024

// processor reset vector, start of the boot code
`define RESET_VECTOR 32'hbfc00000

// reset vector plus largest backward branch
`define BRANCH_BACK_BASE 32'hbfbe0000

// reset vector plus largest forward branch
`define BRANCH_FWD_BASE 32'hbfc1fffc

// highest reachable jump target
`define JUMP_FWD_BASE 32'hb3fffffc

// low window covers bytes 0 to 80
`define LOW_WORDS 21

// each branch or jump window
`define EDGE_WORDS 10

// first store index of every window
`define IDX_BRANCH_BACK 21
`define IDX_BRANCH_FWD 31
`define IDX_JUMP_FWD 41
`define IDX_RESET 60

// reset window runs to the top of the store
`define RESET_WORDS (`MEM_DEPTH - `IDX_RESET)

// bytes per word
`define WORD_BYTES 4

`endif

//--- verilog/mem_pkg.sv
// memory side types
`include "mem_consts.svh"

package mem_pkg;

  // byte address as seen on the bus
  typedef logic [31:0] addr_t;

  // one stored data word
  typedef logic [31:0] word_t;

  // lane enables, bit n covers bits 8n+7 down to 8n
  typedef logic [`WORD_BYTES-1:0] byte_en_t;

  // index into the compact word store
  typedef logic [$clog2(`MEM_DEPTH)-1:0] word_idx_t;

endpackage

//--- verilog/window_decoder.sv
// address window decoder
`include "mem_consts.svh"

module window_decoder
  import mem_pkg::*;
(
  input  addr_t     address,
  output word_idx_t index,
  output logic      addr_ok
);

  // byte offsets from each window base
  // an address below the base wraps to a huge offset and misses
  addr_t off_bb;
  addr_t off_bf;
  addr_t off_jf;
  addr_t off_rst;
  logic  hit;

  // true when the offset lies inside a window of the given size
  function automatic logic in_window(addr_t off, int unsigned words);
    return off < addr_t'(words * `WORD_BYTES);
  endfunction

  // word offset plus first index of the window
  function automatic word_idx_t to_index(addr_t off, int unsigned first);
    return word_idx_t'(off[11:2]) + word_idx_t'(first);
  endfunction

  assign off_bb  = address - `BRANCH_BACK_BASE;
  assign off_bf  = address - `BRANCH_FWD_BASE;
  assign off_jf  = address - `JUMP_FWD_BASE;
  assign off_rst = address - `RESET_VECTOR;

  // windows checked in priority order
  always_comb
  begin
    hit   = 1'b1;
    index = '0;
    if (in_window(address, `LOW_WORDS))
    begin
      // low window starts at zero
      index = to_index(address, 0);
    end
    else if (in_window(off_bb, `EDGE_WORDS))
    begin
      index = to_index(off_bb, `IDX_BRANCH_BACK);
    end
    else if (in_window(off_bf, `EDGE_WORDS))
    begin
      index = to_index(off_bf, `IDX_BRANCH_FWD);
    end
    else if (in_window(off_jf, `EDGE_WORDS))
    begin
      index = to_index(off_jf, `IDX_JUMP_FWD);
    end
    else if (in_window(off_rst, `RESET_WORDS))
    begin
      // boot code fills the rest of the store
      index = to_index(off_rst, `IDX_RESET);
    end
    else
    begin
      // unmapped, index left at zero
      hit = 1'b0;
    end
  end

  // word aligned and inside a window
  assign addr_ok = hit && (address[1:0] == 2'b00);

endmodule

//--- verilog/windowed_mem_top.sv
// windowed avalon memory
module windowed_mem_top
  import mem_pkg::*;
  import bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  addr_t    address,
  input  byte_en_t byteenable,
  input  word_t    writedata,
  input  logic     read,
  input  logic     write,
  output word_t    readdata,
  output logic     waitrequest,
  output resp_t    response
);

  // decoded store index and address check
  word_idx_t index;
  logic      addr_ok;

  // controller to store link
  mem_access_if acc_if ();

  window_decoder dec0 (
    .address (address),
    .index   (index),
    .addr_ok (addr_ok)
  );

  avmm_slave_ctrl ctrl0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .read        (read),
    .write       (write),
    .address_ok  (addr_ok),
    .index       (index),
    .byteenable  (byteenable),
    .writedata   (writedata),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .response    (response),
    .acc         (acc_if.ctrl)
  );

  word_store store0 (
    .clk   (clk),
    .rst_n (rst_n),
    .acc   (acc_if.store)
  );

endmodule

//--- verilog/word_store.sv
// compact word store
`include "mem_consts.svh"

module word_store
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  mem_access_if.store acc
);

  // content undefined until written
  word_t mem [`MEM_DEPTH];

  // byte enables widened to a bit mask
  word_t lane_mask;

  // word currently at the addressed slot
  word_t old_word;

  always_comb
  begin
    for (int i = 0; i < `WORD_BYTES; i++)
    begin
      lane_mask[8*i +: 8] = {8{acc.byteenable[i]}};
    end
  end

  assign old_word = mem[acc.index];

  // write merges enabled lanes into the old word
  // disabled lanes keep their content
  always_ff @(posedge clk)
  begin
    if (acc.en && acc.we)
    begin
      mem[acc.index] <= (old_word & ~lane_mask) | (acc.wdata & lane_mask);
    end
  end

  // read result, disabled lanes forced to zero
  // held until the next read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc.rdata <= '0;
    end
    else if (acc.en && !acc.we)
    begin
      acc.rdata <= old_word & lane_mask;
    end
  end

endmodule
